// File: hw/replay_pkg.sv
package replay_pkg;

  // queue geometry
  localparam int depth = 8;
  localparam int ptr_w = 3;
  // occupancy counts zero to depth inclusive
  localparam int cnt_w = 4;
  localparam int slots = 3;

  // occupancy at which upstream is asked to hold off conflicts
  localparam logic [cnt_w-1:0] skip_level = 4'd4;

  // op field widths
  localparam int addr_w = 44;
  localparam int reg_w = 9;
  localparam int type_w = 2;
  localparam int sz_w = 5;
  localparam int lsq_w = 9;
  localparam int ii_w = 10;

  localparam int op_w = addr_w + reg_w + type_w + sz_w + lsq_w + ii_w;

  // field positions inside one op word, address at the bottom
  localparam int op_addr_lo = 0;
  localparam int op_reg_lo = op_addr_lo + addr_w;
  localparam int op_type_lo = op_reg_lo + reg_w;
  localparam int op_sz_lo = op_type_lo + type_w;
  localparam int op_lsq_lo = op_sz_lo + sz_w;
  localparam int op_ii_lo = op_lsq_lo + lsq_w;

  // row layout: conflict bits on top, then op words with slot 0 lowest
  localparam int row_w = slots + slots * op_w;

endpackage

// File: hw/replay_row_ram.sv
`timescale 1ns/1ns

module replay_row_ram (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [replay_pkg::ptr_w-1:0]  rd_addr,
  input  logic                          rd_en,
  output logic [replay_pkg::row_w-1:0]  rd_data,
  input  logic [replay_pkg::ptr_w-1:0]  wr_addr,
  input  logic [replay_pkg::row_w-1:0]  wr_data,
  input  logic                          wr_en
);

  logic [replay_pkg::row_w-1:0] mem [replay_pkg::depth];
  logic [replay_pkg::ptr_w-1:0] rd_addr_q;

  // read address is the only registered stage on the read side
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // a row written at the held address shows up right after the write edge
  assign rd_data = mem[rd_addr_q];

endmodule

// File: hw/replay_queue_ctrl.sv
`timescale 1ns/1ns

module replay_queue_ctrl (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               except,
  input  logic                                               stall,
  input  logic [replay_pkg::slots-1:0]                       conflict,
  input  logic [replay_pkg::slots-1:0][replay_pkg::op_w-1:0] op_in,
  input  logic                                               issue,
  input  logic                                               row_done,
  output logic [replay_pkg::ptr_w-1:0]                       wr_addr,
  output logic [replay_pkg::row_w-1:0]                       wr_data,
  output logic                                               wr_en,
  output logic [replay_pkg::ptr_w-1:0]                       rd_addr,
  output logic                                               rd_en,
  output logic                                               not_empty,
  output logic                                               skip
);

  // input register
  logic [replay_pkg::slots-1:0]                       conf_q;
  logic [replay_pkg::slots-1:0][replay_pkg::op_w-1:0] op_q;

  logic [replay_pkg::ptr_w-1:0] head;
  logic [replay_pkg::ptr_w-1:0] tail;
  logic [replay_pkg::depth-1:0] valid;
  logic [replay_pkg::cnt_w-1:0] count;
  logic                         retire;

  // conflict bits cleared on except, so a flushed row never gets written
  always_ff @(posedge clk) begin
    if (rst) begin
      conf_q <= '0;
    end else if (except) begin
      conf_q <= '0;
    end else if (!stall) begin
      conf_q <= conflict;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      op_q <= op_in;
    end
  end

  // only rows with some conflict are kept
  assign wr_en = (|conf_q) && !stall && !except;
  assign wr_addr = tail;
  assign wr_data = {conf_q, op_q};

  assign retire = issue && row_done;

  // head row valid means the queue holds something
  assign not_empty = valid[head];

  // next head goes to the RAM early, new head row is ready after a retire
  assign rd_en = issue || except;

  always_comb begin
    if (except) begin
      rd_addr = '0;
    end else if (retire) begin
      rd_addr = head + 1'b1;
    end else begin
      rd_addr = head;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      valid <= '0;
    end else if (except) begin
      head <= '0;
      tail <= '0;
      valid <= '0;
    end else begin
      if (wr_en) begin
        valid[tail] <= 1'b1;
        tail <= tail + 1'b1;
      end
      // head and tail never meet here while full, writes are blocked upstream
      if (retire) begin
        valid[head] <= 1'b0;
        head <= head + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (except) begin
      count <= '0;
    end else begin
      case ({wr_en, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // skip with hysteresis, set at skip_level, cleared only once drained
  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
    end else if (count >= replay_pkg::skip_level) begin
      skip <= 1'b1;
    end else if (count == '0) begin
      skip <= 1'b0;
    end
  end

endmodule

// File: hw/replay_slot_pick.sv
`timescale 1ns/1ns

module replay_slot_pick (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         except,
  input  logic                         stall,
  input  logic                         read_en,
  input  logic                         not_empty,
  input  logic [replay_pkg::row_w-1:0] row,
  output logic                         issue,
  output logic                         row_done,
  output logic [replay_pkg::op_w-1:0]  op_out
);

  // slots of the head row not issued yet
  logic [replay_pkg::slots-1:0] mask;
  logic [replay_pkg::slots-1:0] row_conf;
  logic [replay_pkg::slots-1:0] pend;
  logic [replay_pkg::slots-1:0] sel;
  logic [replay_pkg::slots-1:0] rest;

  assign row_conf = row[replay_pkg::row_w-1 -: replay_pkg::slots];
  assign pend = row_conf & mask;

  // lowest pending slot, one hot
  assign sel = pend & (~pend + 1'b1);
  assign rest = pend & ~sel;

  assign issue = not_empty && read_en && !stall && !except && (|pend);
  // last conflicted slot of the row goes out this cycle
  assign row_done = issue && !(|rest);

  always_comb begin
    op_out = '0;
    for (int k = 0; k < replay_pkg::slots; k++) begin
      op_out = op_out |
               ({replay_pkg::op_w{sel[k]}} & row[k*replay_pkg::op_w +: replay_pkg::op_w]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mask <= '1;
    end else if (except) begin
      mask <= '1;
    end else if (issue) begin
      // reload for the next row once this one retires
      if (row_done) begin
        mask <= '1;
      end else begin
        mask <= mask & ~sel;
      end
    end
  end

endmodule

// File: hw/agu_replay_cam.sv
`timescale 1ns/1ns

module agu_replay_cam (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          except,
  input  logic                          read_en,
  input  logic                          stall,
  input  logic                          conflict0,
  input  logic [replay_pkg::addr_w-1:0] op0_addr,
  input  logic [replay_pkg::reg_w-1:0]  op0_reg_no,
  input  logic [replay_pkg::type_w-1:0] op0_type,
  input  logic [replay_pkg::sz_w-1:0]   op0_sz,
  input  logic [replay_pkg::lsq_w-1:0]  op0_lsq,
  input  logic [replay_pkg::ii_w-1:0]   op0_ii,
  input  logic                          conflict1,
  input  logic [replay_pkg::addr_w-1:0] op1_addr,
  input  logic [replay_pkg::reg_w-1:0]  op1_reg_no,
  input  logic [replay_pkg::type_w-1:0] op1_type,
  input  logic [replay_pkg::sz_w-1:0]   op1_sz,
  input  logic [replay_pkg::lsq_w-1:0]  op1_lsq,
  input  logic [replay_pkg::ii_w-1:0]   op1_ii,
  input  logic                          conflict2,
  input  logic [replay_pkg::addr_w-1:0] op2_addr,
  input  logic [replay_pkg::reg_w-1:0]  op2_reg_no,
  input  logic [replay_pkg::type_w-1:0] op2_type,
  input  logic [replay_pkg::sz_w-1:0]   op2_sz,
  input  logic [replay_pkg::lsq_w-1:0]  op2_lsq,
  input  logic [replay_pkg::ii_w-1:0]   op2_ii,
  output logic                          skip,
  output logic                          out_valid,
  output logic [replay_pkg::addr_w-1:0] out_addr,
  output logic [replay_pkg::reg_w-1:0]  out_reg_no,
  output logic [replay_pkg::type_w-1:0] out_type,
  output logic [replay_pkg::sz_w-1:0]   out_sz,
  output logic [replay_pkg::lsq_w-1:0]  out_lsq,
  output logic [replay_pkg::ii_w-1:0]   out_ii
);

  logic [replay_pkg::slots-1:0]                       conflict;
  logic [replay_pkg::slots-1:0][replay_pkg::op_w-1:0] op_word;
  logic [replay_pkg::ptr_w-1:0]                       wr_addr;
  logic [replay_pkg::row_w-1:0]                       wr_data;
  logic                                               wr_en;
  logic [replay_pkg::ptr_w-1:0]                       rd_addr;
  logic                                               rd_en;
  logic [replay_pkg::row_w-1:0]                       row_data;
  logic                                               not_empty;
  logic                                               issue;
  logic                                               row_done;
  logic [replay_pkg::op_w-1:0]                        op_sel;

  assign conflict = {conflict2, conflict1, conflict0};

  // slot 0 op word
  assign op_word[0][replay_pkg::op_addr_lo +: replay_pkg::addr_w] = op0_addr;
  assign op_word[0][replay_pkg::op_reg_lo +: replay_pkg::reg_w] = op0_reg_no;
  assign op_word[0][replay_pkg::op_type_lo +: replay_pkg::type_w] = op0_type;
  assign op_word[0][replay_pkg::op_sz_lo +: replay_pkg::sz_w] = op0_sz;
  assign op_word[0][replay_pkg::op_lsq_lo +: replay_pkg::lsq_w] = op0_lsq;
  assign op_word[0][replay_pkg::op_ii_lo +: replay_pkg::ii_w] = op0_ii;

  // slot 1
  assign op_word[1][replay_pkg::op_addr_lo +: replay_pkg::addr_w] = op1_addr;
  assign op_word[1][replay_pkg::op_reg_lo +: replay_pkg::reg_w] = op1_reg_no;
  assign op_word[1][replay_pkg::op_type_lo +: replay_pkg::type_w] = op1_type;
  assign op_word[1][replay_pkg::op_sz_lo +: replay_pkg::sz_w] = op1_sz;
  assign op_word[1][replay_pkg::op_lsq_lo +: replay_pkg::lsq_w] = op1_lsq;
  assign op_word[1][replay_pkg::op_ii_lo +: replay_pkg::ii_w] = op1_ii;

  // slot 2
  assign op_word[2][replay_pkg::op_addr_lo +: replay_pkg::addr_w] = op2_addr;
  assign op_word[2][replay_pkg::op_reg_lo +: replay_pkg::reg_w] = op2_reg_no;
  assign op_word[2][replay_pkg::op_type_lo +: replay_pkg::type_w] = op2_type;
  assign op_word[2][replay_pkg::op_sz_lo +: replay_pkg::sz_w] = op2_sz;
  assign op_word[2][replay_pkg::op_lsq_lo +: replay_pkg::lsq_w] = op2_lsq;
  assign op_word[2][replay_pkg::op_ii_lo +: replay_pkg::ii_w] = op2_ii;

  replay_queue_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .stall     (stall),
    .conflict  (conflict),
    .op_in     (op_word),
    .issue     (issue),
    .row_done  (row_done),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_en     (wr_en),
    .rd_addr   (rd_addr),
    .rd_en     (rd_en),
    .not_empty (not_empty),
    .skip      (skip)
  );

  replay_row_ram i_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (rd_addr),
    .rd_en   (rd_en),
    .rd_data (row_data),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_en   (wr_en)
  );

  replay_slot_pick i_pick (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .stall     (stall),
    .read_en   (read_en),
    .not_empty (not_empty),
    .row       (row_data),
    .issue     (issue),
    .row_done  (row_done),
    .op_out    (op_sel)
  );

  // issued op, fields only meaningful with out_valid
  assign out_valid = issue;
  assign out_addr = op_sel[replay_pkg::op_addr_lo +: replay_pkg::addr_w];
  assign out_reg_no = op_sel[replay_pkg::op_reg_lo +: replay_pkg::reg_w];
  assign out_type = op_sel[replay_pkg::op_type_lo +: replay_pkg::type_w];
  assign out_sz = op_sel[replay_pkg::op_sz_lo +: replay_pkg::sz_w];
  assign out_lsq = op_sel[replay_pkg::op_lsq_lo +: replay_pkg::lsq_w];
  assign out_ii = op_sel[replay_pkg::op_ii_lo +: replay_pkg::ii_w];

endmodule

// File: verif/replay_sva.sv
`timescale 1ns/1ns

module replay_sva (
  input logic                         clk,
  input logic                         rst,
  input logic                         except,
  input logic                         wr_en,
  input logic [replay_pkg::cnt_w-1:0] count,
  input logic                         skip
);

  // a write into a full queue would overrun the head row
  a_no_write_full: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> int'(count) < replay_pkg::depth
  ) else $error("row written while the queue is full");

  a_skip_reset: assert property (
    @(posedge clk) rst |=> !skip
  ) else $error("skip high after reset");

  // skip follows the count one edge later
  a_skip_level: assert property (
    @(posedge clk) disable iff (rst) count >= replay_pkg::skip_level |=> skip
  ) else $error("skip low with occupancy at or above skip_level");

  a_flush_count: assert property (
    @(posedge clk) disable iff (rst) except |=> count == '0
  ) else $error("occupancy not cleared after except");

endmodule

bind replay_queue_ctrl replay_sva i_sva (
  .clk    (clk),
  .rst    (rst),
  .except (except),
  .wr_en  (wr_en),
  .count  (count),
  .skip   (skip)
);

// File: verif/tb_agu_replay_cam.sv
`timescale 1ns/1ns

module tb_agu_replay_cam;

  localparam int rand_cycles = 400;
  // directed tests plus drains stay well inside this budget
  localparam int stim_cycles = rand_cycles + 250;

  logic                          clk;
  logic                          rst;
  logic                          except;
  logic                          read_en;
  logic                          stall;
  logic [replay_pkg::slots-1:0]  conf;
  logic [replay_pkg::addr_w-1:0] addr [replay_pkg::slots];
  logic [replay_pkg::reg_w-1:0]  reg_no [replay_pkg::slots];
  logic [replay_pkg::type_w-1:0] op_type [replay_pkg::slots];
  logic [replay_pkg::sz_w-1:0]   sz [replay_pkg::slots];
  logic [replay_pkg::lsq_w-1:0]  lsq [replay_pkg::slots];
  logic [replay_pkg::ii_w-1:0]   ii [replay_pkg::slots];
  logic                          skip;
  logic                          out_valid;
  logic [replay_pkg::addr_w-1:0] out_addr;
  logic [replay_pkg::reg_w-1:0]  out_reg_no;
  logic [replay_pkg::type_w-1:0] out_type;
  logic [replay_pkg::sz_w-1:0]   out_sz;
  logic [replay_pkg::lsq_w-1:0]  out_lsq;
  logic [replay_pkg::ii_w-1:0]   out_ii;

  // expected rows oldest first with the pending slots in the top bits
  logic [replay_pkg::row_w-1:0] model_q [$];
  int n_checks;
  int n_mismatch;
  int n_other;

  agu_replay_cam i_dut (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .read_en    (read_en),
    .stall      (stall),
    .conflict0  (conf[0]),
    .op0_addr   (addr[0]),
    .op0_reg_no (reg_no[0]),
    .op0_type   (op_type[0]),
    .op0_sz     (sz[0]),
    .op0_lsq    (lsq[0]),
    .op0_ii     (ii[0]),
    .conflict1  (conf[1]),
    .op1_addr   (addr[1]),
    .op1_reg_no (reg_no[1]),
    .op1_type   (op_type[1]),
    .op1_sz     (sz[1]),
    .op1_lsq    (lsq[1]),
    .op1_ii     (ii[1]),
    .conflict2  (conf[2]),
    .op2_addr   (addr[2]),
    .op2_reg_no (reg_no[2]),
    .op2_type   (op_type[2]),
    .op2_sz     (sz[2]),
    .op2_lsq    (lsq[2]),
    .op2_ii     (ii[2]),
    .skip       (skip),
    .out_valid  (out_valid),
    .out_addr   (out_addr),
    .out_reg_no (out_reg_no),
    .out_type   (out_type),
    .out_sz     (out_sz),
    .out_lsq    (out_lsq),
    .out_ii     (out_ii)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [replay_pkg::op_w-1:0] pack_op(input int k);
    return {ii[k], lsq[k], sz[k], op_type[k], reg_no[k], addr[k]};
  endfunction

  // lowest conflicted slot not yet issued in the oldest row
  function automatic logic [replay_pkg::op_w-1:0] expected_op(
    input logic [replay_pkg::row_w-1:0] r
  );
    logic [replay_pkg::slots-1:0] pend;
    pend = r[replay_pkg::row_w-1 -: replay_pkg::slots];
    for (int k = 0; k < replay_pkg::slots; k++) begin
      if (pend[k]) begin
        return r[k*replay_pkg::op_w +: replay_pkg::op_w];
      end
    end
    return '0;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic set_inputs(input logic [replay_pkg::slots-1:0] c);
    logic [63:0] wide;
    for (int k = 0; k < replay_pkg::slots; k++) begin
      wide = {$urandom, $urandom};
      addr[k] = wide[replay_pkg::addr_w-1:0];
      wide = {$urandom, $urandom};
      reg_no[k] = wide[replay_pkg::reg_w-1:0];
      op_type[k] = wide[16 +: replay_pkg::type_w];
      sz[k] = wide[24 +: replay_pkg::sz_w];
      lsq[k] = wide[32 +: replay_pkg::lsq_w];
      ii[k] = wide[48 +: replay_pkg::ii_w];
    end
    conf = c;
  endtask

  task automatic drain(input int max_cycles);
    read_en = 1'b1;
    set_inputs('0);
    for (int n = 0; n < max_cycles && model_q.size() != 0; n++) begin
      next_cycle();
    end
    if (model_q.size() != 0) begin
      n_other++;
      $display("queue did not drain within %0d cycles", max_cycles);
    end
    repeat (2) next_cycle();
  endtask

  task automatic wait_for_skip(input logic level, input int max_cycles);
    for (int n = 0; n < max_cycles && skip != level; n++) begin
      next_cycle();
    end
    if (skip != level) begin
      n_other++;
      $display("skip did not reach %0d within %0d cycles", level, max_cycles);
    end
  endtask

  // an op seen mid-cycle issues on the next rising edge
  always @(negedge clk) begin : compare
    logic [replay_pkg::op_w-1:0]  exp_op;
    logic [replay_pkg::slots-1:0] pend;
    if (!rst) begin
      if (stall || except) begin
        check("out_valid", 64'(out_valid), 64'd0);
      end
      if (out_valid && model_q.size() == 0) begin
        n_other++;
        $display("out_valid high at %0t but no op was expected", $time);
      end else if (out_valid) begin
        exp_op = expected_op(model_q[0]);
        check("out_addr", 64'(out_addr),
              64'(exp_op[replay_pkg::op_addr_lo +: replay_pkg::addr_w]));
        check("out_reg_no", 64'(out_reg_no),
              64'(exp_op[replay_pkg::op_reg_lo +: replay_pkg::reg_w]));
        check("out_type", 64'(out_type),
              64'(exp_op[replay_pkg::op_type_lo +: replay_pkg::type_w]));
        check("out_sz", 64'(out_sz),
              64'(exp_op[replay_pkg::op_sz_lo +: replay_pkg::sz_w]));
        check("out_lsq", 64'(out_lsq),
              64'(exp_op[replay_pkg::op_lsq_lo +: replay_pkg::lsq_w]));
        check("out_ii", 64'(out_ii),
              64'(exp_op[replay_pkg::op_ii_lo +: replay_pkg::ii_w]));
        pend = model_q[0][replay_pkg::row_w-1 -: replay_pkg::slots];
        pend = pend & (pend - 1'b1);
        if (pend == '0) begin
          model_q.delete(0);
        end else begin
          model_q[0][replay_pkg::row_w-1 -: replay_pkg::slots] = pend;
        end
      end
      // row sampled on the coming edge
      if (except) begin
        model_q.delete();
      end else if (!stall && conf != '0) begin
        model_q.push_back({conf, pack_op(2), pack_op(1), pack_op(0)});
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    void'($urandom(20083));
    n_checks = 0;
    n_mismatch = 0;
    n_other = 0;
    rst = 1'b1;
    except = 1'b0;
    read_en = 1'b0;
    stall = 1'b0;
    set_inputs('0);
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // single op into an empty queue and then a row without conflicts
    read_en = 1'b1;
    set_inputs(3'b010);
    next_cycle();
    set_inputs('0);
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd0);
    next_cycle();
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd1);
    drain(10);
    repeat (4) next_cycle();

    // slots 0 and 2 only
    set_inputs(3'b101);
    next_cycle();
    drain(10);

    // random rows and read_en gaps with upstream obeying skip
    for (int n = 0; n < rand_cycles; n++) begin
      r = $urandom;
      read_en = (r[1:0] != 2'b00);
      set_inputs((skip || r[4:3] == 2'b00) ? 3'b000 : r[7:5]);
      next_cycle();
    end
    drain(100);

    // fill past skip_level with issue held off
    read_en = 1'b0;
    for (int n = 0; n < 5; n++) begin
      set_inputs(skip ? 3'b000 : 3'b111);
      next_cycle();
    end
    set_inputs('0);
    wait_for_skip(1'b1, 8);
    read_en = 1'b1;
    wait_for_skip(1'b0, 60);
    if (model_q.size() != 0) begin
      n_other++;
      $display("skip fell while ops were still queued");
    end

    // flush with rows queued and one in flight
    read_en = 1'b0;
    set_inputs(3'b011);
    next_cycle();
    set_inputs(3'b110);
    next_cycle();
    set_inputs(3'b111);
    next_cycle();
    except = 1'b1;
    read_en = 1'b1;
    set_inputs(3'b101);
    next_cycle();
    except = 1'b0;
    set_inputs('0);
    repeat (6) next_cycle();
    set_inputs(3'b001);
    next_cycle();
    set_inputs(3'b100);
    next_cycle();
    drain(20);

    // freeze mid-replay while the inputs keep changing
    for (int n = 0; n < 3; n++) begin
      set_inputs(3'b111);
      next_cycle();
    end
    stall = 1'b1;
    for (int n = 0; n < 6; n++) begin
      r = $urandom;
      set_inputs(r[2:0]);
      next_cycle();
    end
    stall = 1'b0;
    drain(40);

    if (model_q.size() != 0) begin
      n_other++;
      $display("%0d rows still expected at the end of the run", model_q.size());
    end
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((stim_cycles + 200) * 40);
    $display("run did not finish within %0d cycles", stim_cycles + 200);
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: build.f
hw/replay_pkg.sv
hw/replay_row_ram.sv
hw/replay_queue_ctrl.sv
hw/replay_slot_pick.sv
hw/agu_replay_cam.sv
verif/replay_sva.sv
verif/tb_agu_replay_cam.sv

// File: Makefile
TOP := tb_agu_replay_cam

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'ALL CHECKS PASSED'

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
